// ==== bench/rv_core_properties.sv ====
`timescale 1ns/10ps

module rv_core_properties (
  input logic                  clk,
  input logic                  rst,
  input rv_isa_pkg::xlen_t     pc,
  input logic                  halt,
  input logic                  wb_valid,
  input rv_isa_pkg::reg_addr_t wb_rd
);
  import rv_isa_pkg::*;

  int failures = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) (pc % insn_bytes) == '0)
  else
  begin
    failures++;
    $error("pc %h is not word aligned", pc);
  end

  // halt is sticky and freezes the pc
  halt_freezes_pc: assert property (
    @(posedge clk) disable iff (rst) halt |=> (halt && $stable(pc)))
  else
  begin
    failures++;
    $error("pc moved or halt dropped after halt, pc %h", pc);
  end

  no_x0_commit: assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0)
  else
  begin
    failures++;
    $error("commit trace shows a write to x0");
  end

endmodule

bind commit_stage rv_core_properties u_props (.*);

// ==== bench/rv_core_stimulus.txt ====
// header: program length, commit count, final pc
// then program words from address 0, then commit records as rd data pairs
0000001d 00000011 00000070
800000b7 ffb00113  // 00 lui x1 0x80000, addi x2 -5
00700193 4040d213  // 08 addi x3 7, srai x4 x1 4
00012293 00513313  // 10 slti x5, sltiu x6
fff1c393 00118013  // 18 xori x7 -1, addi to x0 (no commit)
40218433 4030d4b3  // 20 sub x8, sra x9
00312533 003135b3  // 28 slt x10, sltu x11 on opposite signs
02106613 00c196b3  // 30 ori x12 33, sll x13 by x12 (low 5 bits = 1)
00300733 00318463  // 38 add x14 reading x0, beq taken
00100793 00319463  // 40 skipped, bne not taken
00219813 00314463  // 48 slli x16, blt taken
00300793 00315463  // 50 skipped, bge not taken
01c15893 00316463  // 58 srli x17 28, bltu not taken
0f017913 00317463  // 60 andi x18, bgeu taken
00600793 00000073  // 68 skipped, ecall
00700993           // 70 fetched after halt, never commits
01 80000000 02 fffffffb
03 00000007 04 f8000000
05 00000001 06 00000000
07 fffffff8 08 0000000c
09 ff000000 0a 00000001
0b 00000000 0c 00000021
0d 0000000e 0e 00000007
10 0000001c 11 0000000f
12 000000f0

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;
  import rv_isa_pkg::*;

  // program length, commit count and final pc sit ahead of the image
  localparam int hdr_words = 3;
  localparam int halt_watch = 4;

  logic clk;
  logic rst;
  xlen_t insn;
  xlen_t pc;
  logic halt;
  logic wb_valid;
  reg_addr_t wb_rd;
  xlen_t wb_data;

  xlen_t stim [256];
  int prog_len;
  int exp_commits;
  int commits;
  int cycles;
  int cycle_limit;
  int value_errors;
  int other_errors;
  int prop_errors;

  rv_core_top UUT (.*);

  always #2 clk = ~clk;

  // past the image the word follows the address; low bits 00 never decode
  function automatic xlen_t fetch_word(xlen_t addr);
    xlen_t idx;
    idx = addr / insn_bytes;
    if (idx < xlen_t'(prog_len))
      return stim[hdr_words + idx];
    else
      return {addr[31:2], 2'b00};
  endfunction

  task automatic check_addr(string name, reg_addr_t expected, reg_addr_t actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("FAIL %s expected x%0d actual x%0d", name, expected, actual);
    end
  endtask

  task automatic check_data(string name, xlen_t expected, xlen_t actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected)
    begin
      value_errors++;
      $display("FAIL %s expected %b actual %b", name, expected, actual);
    end
  endtask

  // records follow the image as rd and data pairs
  task automatic check_commit();
    int rec;
    rec = hdr_words + prog_len + 2 * commits;
    if (commits < exp_commits)
    begin
      check_addr($sformatf("commit %0d rd", commits), reg_addr_t'(stim[rec]), wb_rd);
      check_data($sformatf("commit %0d data", commits), stim[rec + 1], wb_data);
    end
    else
    begin
      other_errors++;
      $display("commit to x%0d seen after the last expected record", wb_rd);
    end
    commits++;
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    insn = '0;
    commits = 0;
    cycles = 0;
    value_errors = 0;
    other_errors = 0;
    $readmemh("bench/rv_core_stimulus.txt", stim);
    prog_len = int'(stim[0]);
    exp_commits = int'(stim[1]);
    cycle_limit = 4 * prog_len + 20;

    repeat (5) @(posedge clk);
    @(negedge clk);
    check_data("reset pc", '0, pc);
    check_flag("reset halt", 1'b0, halt);
    check_flag("reset wb_valid", 1'b0, wb_valid);
    rst = 1'b0;
    insn = fetch_word(pc);

    // one retirement per cycle until ECALL
    while (!halt && cycles < cycle_limit)
    begin
      @(negedge clk);
      cycles++;
      if (wb_valid)
        check_commit();
      insn = fetch_word(pc);
    end

    if (!halt)
    begin
      other_errors++;
      $display("timeout: core did not halt within %0d cycles", cycles);
    end
    else
    begin
      check_data("final pc", stim[2], pc);
      // pc must stay frozen with no further commits
      repeat (halt_watch)
      begin
        @(negedge clk);
        check_data("pc after halt", stim[2], pc);
        check_flag("halt held", 1'b1, halt);
        if (wb_valid)
          check_commit();
      end
      if (commits != exp_commits)
      begin
        other_errors++;
        $display("saw %0d commits but the file expects %0d", commits, exp_commits);
      end
    end

    prop_errors = UUT.u_commit.u_props.failures;
    $display("errors: %0d value, %0d other, %0d assertion; %0d commits",
             value_errors, other_errors, prop_errors, commits);
    if (value_errors + other_errors + prop_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
  input  rv_isa_pkg::xlen_t rs1_data,
  input  rv_isa_pkg::xlen_t rs2_data,
  decoded_insn_if.consumer  dec,
  output rv_isa_pkg::xlen_t alu_result
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  xlen_t op_b;
  logic [4:0] shamt;

  assign op_b = dec.use_imm ? dec.imm : rs2_data;
  // low 5 bits only, for both register and immediate shifts
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      alu_add:
        alu_result = rs1_data + op_b;
      alu_sub:
        alu_result = rs1_data - op_b;
      alu_sll:
        alu_result = rs1_data << shamt;
      alu_slt:
        alu_result = ($signed(rs1_data) < $signed(op_b)) ? 32'd1 : 32'd0;
      alu_sltu:
        alu_result = (rs1_data < op_b) ? 32'd1 : 32'd0;
      alu_xor:
        alu_result = rs1_data ^ op_b;
      alu_srl:
        alu_result = rs1_data >> shamt;
      alu_sra:
        alu_result = xlen_t'($signed(rs1_data) >>> shamt);
      alu_or:
        alu_result = rs1_data | op_b;
      alu_and:
        alu_result = rs1_data & op_b;
      alu_pass_b:
        alu_result = op_b;
      default:
        alu_result = '0;
    endcase
  end

endmodule

// ==== design/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit (
  input  rv_isa_pkg::xlen_t pc,
  input  rv_isa_pkg::xlen_t rs1_data,
  input  rv_isa_pkg::xlen_t rs2_data,
  decoded_insn_if.consumer  dec,
  output logic              taken,
  output rv_isa_pkg::xlen_t target
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  logic cond_true;
  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb
  begin
    case (dec.cond)
      beq:     cond_true = eq;
      bne:     cond_true = !eq;
      blt:     cond_true = lt_s;
      bge:     cond_true = !lt_s;
      bltu:    cond_true = lt_u;
      bgeu:    cond_true = !lt_u;
      default: cond_true = 1'b0;
    endcase
  end

  assign taken = dec.is_branch && cond_true;
  // B immediate is already sign-extended with bit 0 clear
  assign target = pc + dec.imm;

endmodule

// ==== design/commit_stage.sv ====
`timescale 1ns/10ps

module commit_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::xlen_t     alu_result,
  input  logic                  taken,
  input  rv_isa_pkg::xlen_t     target,
  decoded_insn_if.consumer      dec,
  output rv_isa_pkg::xlen_t     pc,
  output logic                  halt,
  output logic                  wr_en,
  output rv_isa_pkg::reg_addr_t wr_addr,
  output rv_isa_pkg::xlen_t     wr_data,
  output logic                  wb_valid,
  output rv_isa_pkg::reg_addr_t wb_rd,
  output rv_isa_pkg::xlen_t     wb_data
);
  import rv_isa_pkg::*;

  xlen_t pc_next;

  // frozen once halted; ECALL itself still steps past
  assign pc_next = halt  ? pc :
                   taken ? target :
                           pc + insn_bytes;

  assign wr_en = dec.writes_rd && (dec.rd != '0) && !halt;
  assign wr_addr = dec.rd;
  assign wr_data = alu_result;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= '0;
      halt <= 1'b0;
      wb_valid <= 1'b0;
    end
    else
    begin
      pc <= pc_next;
      // sticky until reset
      halt <= halt || dec.is_halt;
      wb_valid <= wr_en;
    end
  end

  // commit trace payload
  always_ff @(posedge clk)
  begin
    wb_rd <= wr_addr;
    wb_data <= wr_data;
  end

endmodule

// ==== design/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] branch_cond_t;

  // ALU operation codes
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_sll = 4'd2;
  localparam alu_op_t alu_slt = 4'd3;
  localparam alu_op_t alu_sltu = 4'd4;
  localparam alu_op_t alu_xor = 4'd5;
  localparam alu_op_t alu_srl = 4'd6;
  localparam alu_op_t alu_sra = 4'd7;
  localparam alu_op_t alu_or = 4'd8;
  localparam alu_op_t alu_and = 4'd9;
  // second operand straight through, used by LUI
  localparam alu_op_t alu_pass_b = 4'd10;

  // branch conditions, same values as the branch funct3 field
  localparam branch_cond_t beq = 3'b000;
  localparam branch_cond_t bne = 3'b001;
  localparam branch_cond_t blt = 3'b100;
  localparam branch_cond_t bge = 3'b101;
  localparam branch_cond_t bltu = 3'b110;
  localparam branch_cond_t bgeu = 3'b111;

endpackage

// ==== design/decoded_insn_if.sv ====
`timescale 1ns/10ps

interface decoded_insn_if;

  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::xlen_t imm;
  core_ctrl_pkg::alu_op_t alu_op;
  // second operand from imm rather than rs2
  logic use_imm;
  logic writes_rd;
  logic is_branch;
  core_ctrl_pkg::branch_cond_t cond;
  logic is_halt;

  modport producer (
    output rd, rs1, imm, alu_op, use_imm, writes_rd, is_branch, cond, is_halt
  );

  modport consumer (
    input rd, rs1, imm, alu_op, use_imm, writes_rd, is_branch, cond, is_halt
  );

endinterface

// ==== design/insn_decoder.sv ====
`timescale 1ns/10ps

module insn_decoder (
  input  rv_isa_pkg::xlen_t     insn,
  output rv_isa_pkg::reg_addr_t rs2,
  decoded_insn_if.producer      dec
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  xlen_t imm_i;
  xlen_t imm_b;
  xlen_t imm_u;
  logic alt;
  logic f7_zero;
  alu_op_t arith_op;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign dec.rd = insn[11:7];
  assign dec.rs1 = insn[19:15];
  assign rs2 = insn[24:20];
  assign dec.cond = funct3;

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  // upper 20 bits over 12 zeros
  assign imm_u = {insn[31:12], 12'd0};

  assign alt = (funct7 == funct7_alt);
  assign f7_zero = (funct7 == 7'd0);

  // operation shared by the immediate and register groups
  always_comb
  begin
    case (funct3)
      f3_add_sub: arith_op = (alt && opcode == op_reg_reg) ? alu_sub : alu_add;
      f3_sll:     arith_op = alu_sll;
      f3_slt:     arith_op = alu_slt;
      f3_sltu:    arith_op = alu_sltu;
      f3_xor:     arith_op = alu_xor;
      f3_srl_sra: arith_op = alt ? alu_sra : alu_srl;
      f3_or:      arith_op = alu_or;
      default:    arith_op = alu_and;
    endcase
  end

  always_comb
  begin
    dec.imm = imm_i;
    dec.alu_op = arith_op;
    dec.use_imm = 1'b0;
    dec.writes_rd = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_halt = 1'b0;
    case (opcode)
      op_lui:
      begin
        dec.imm = imm_u;
        dec.alu_op = alu_pass_b;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
      end
      op_reg_imm:
      begin
        dec.use_imm = 1'b1;
        // shift immediates restrict the upper bits
        if (funct3 == f3_sll)
          dec.writes_rd = f7_zero;
        else if (funct3 == f3_srl_sra)
          dec.writes_rd = f7_zero || alt;
        else
          dec.writes_rd = 1'b1;
      end
      op_reg_reg:
      begin
        dec.writes_rd = f7_zero ||
                        (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
      end
      op_branch:
      begin
        dec.imm = imm_b;
        case (funct3)
          beq, bne, blt, bge, bltu, bgeu: dec.is_branch = 1'b1;
          default: dec.is_branch = 1'b0;
        endcase
      end
      op_system:
      begin
        // only ECALL, everything else in this opcode is a no-op
        dec.is_halt = (insn[31:7] == 25'd0);
      end
      default:
      begin
        dec.writes_rd = 1'b0;
      end
    endcase
  end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/10ps

module register_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  input  rv_isa_pkg::reg_addr_t wr_addr,
  input  logic                  wr_en,
  input  rv_isa_pkg::xlen_t     wr_data,
  output rv_isa_pkg::xlen_t     rs1_data,
  output rv_isa_pkg::xlen_t     rs2_data
);
  import rv_isa_pkg::*;

  xlen_t regs [num_regs];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en && wr_addr != '0)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/10ps

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::xlen_t     insn,
  output rv_isa_pkg::xlen_t     pc,
  output logic                  halt,
  output logic                  wb_valid,
  output rv_isa_pkg::reg_addr_t wb_rd,
  output rv_isa_pkg::xlen_t     wb_data
);
  import rv_isa_pkg::*;

  reg_addr_t rs2_addr;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t alu_result;
  logic taken;
  xlen_t target;
  logic wr_en;
  reg_addr_t wr_addr;
  xlen_t wr_data;

  decoded_insn_if dec_if ();

  insn_decoder u_decoder (
    .insn (insn),
    .rs2  (rs2_addr),
    .dec  (dec_if.producer)
  );

  // rs1 index rides on the decoded bundle, rs2 comes separately
  register_file u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec_if.rs1),
    .rs2      (rs2_addr),
    .wr_addr  (wr_addr),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu_unit u_alu (
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dec        (dec_if.consumer),
    .alu_result (alu_result)
  );

  branch_unit u_branch (
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec_if.consumer),
    .taken    (taken),
    .target   (target)
  );

  commit_stage u_commit (
    .clk        (clk),
    .rst        (rst),
    .alu_result (alu_result),
    .taken      (taken),
    .target     (target),
    .dec        (dec_if.consumer),
    .pc         (pc),
    .halt       (halt),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // base integer width
  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes kept by the core
  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_system = 7'b1110011;

  // funct3 for both ALU groups
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll = 3'b001;
  localparam funct3_t f3_slt = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or = 3'b110;
  localparam funct3_t f3_and = 3'b111;

  // selects SUB and SRA/SRAI
  localparam funct7_t funct7_alt = 7'b0100000;

  // one instruction per word
  localparam xlen_t insn_bytes = 32'd4;

endpackage

// ==== flist.f ====
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/decoded_insn_if.sv
design/insn_decoder.sv
design/register_file.sv
design/alu_unit.sv
design/branch_unit.sv
design/commit_stage.sv
design/rv_core_top.sv
bench/rv_core_properties.sv
bench/rv_core_tb.sv
